/* msi_pkg.sv */
/*
  shared widths, counts and the vector table write word of the msi
  interrupt controller
  rtl files pull it in with a wildcard import inside the module body
*/
package msi_pkg;

	// ==========================================================
	// priorities and cores
	// ==========================================================
	localparam int NUM_PRI = 15;	// queues 1..15, priority 0 is never queued
	localparam int PRI_W = 4;
	localparam int CORE_W = 6;
	localparam logic [CORE_W-1:0] BCAST_CORE = 6'd63;	// accepted by every core

	// ==========================================================
	// vector table and message words
	// ==========================================================
	localparam int VEC_W = 6;
	localparam int NUM_VEC = 64;	// one entry per vector number
	localparam int ADR_W = 40;	// isr address
	localparam int DAT_W = 32;	// isr data and message data
	localparam int MSG_W = VEC_W + DAT_W;	// queued word is {vector, data}

	// per priority queue
	localparam int QDEPTH = 4;
	localparam int QPTR_W = $clog2(QDEPTH);	// pointers wrap, so keep QDEPTH a power of two

	// table write word
	// the address half takes the whole word
	// the control half keeps data in the low bits and the mask above it
	typedef union packed {
		logic [ADR_W-1:0] adr_view;	// whalf = 0
		struct packed {
			logic [ADR_W-DAT_W-2:0] resv;	// write as zero
			logic mask;	// 1 = entry masked
			logic [DAT_W-1:0] dat;	// isr data word
		} ctl_view;	// whalf = 1
	} vt_wword_u;

endpackage

/* msi_queue.sv */
/*
  small synchronous fifo for the messages of one priority
  head word is valid whenever the queue is not empty
  writes to a full queue and pops of an empty queue are ignored
*/
`timescale 1ns/10ps

module msi_queue (
	input  logic clk,
	input  logic rst,
	input  logic wr_i,
	input  logic [msi_pkg::MSG_W-1:0] din_i,
	input  logic rd_i,	// pop the head on this edge
	output logic empty_o,
	output logic full_o,
	output logic [msi_pkg::MSG_W-1:0] dout_o	// head word
);
	import msi_pkg::*;

	logic [MSG_W-1:0] mem [QDEPTH];	// circular buffer
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [QPTR_W:0] count;	// 0..QDEPTH
	logic do_wr;
	logic do_rd;

	// ==========================================================
	// flags and qualified strobes
	// ==========================================================
	assign empty_o = (count == '0);
	assign full_o = (count == (QPTR_W+1)'(QDEPTH));
	assign do_wr = wr_i && !full_o;	// full queue drops the write
	assign do_rd = rd_i && !empty_o;

	// storage
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din_i;
	end

	assign dout_o = mem[rd_ptr];	// first in, first out

	// ==========================================================
	// pointers and fill count
	// ==========================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;	// natural wrap
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

endmodule

/* msi_intake.sv */
/*
  message intake of the msi controller
  registers an incoming message, filters it by core and priority
  and raises the write strobe of the matching priority queue
  also holds the sticky queue-full flag
*/
`timescale 1ns/10ps

module msi_intake (
	input  logic clk,
	input  logic rst,
	input  logic msg_valid_i,	// one-cycle strobe
	input  logic [msi_pkg::CORE_W-1:0] msg_core_i,
	input  logic [msi_pkg::PRI_W-1:0] msg_pri_i,
	input  logic [msi_pkg::VEC_W-1:0] msg_vec_i,
	input  logic [msi_pkg::DAT_W-1:0] msg_dat_i,
	input  logic [msi_pkg::CORE_W-1:0] coreno_i,	// this core's number
	input  logic [msi_pkg::NUM_PRI:1] q_full_i,
	input  logic full_clr_i,
	output logic [msi_pkg::NUM_PRI:1] q_wr_o,	// one-hot, bit = priority
	output logic [msi_pkg::MSG_W-1:0] q_din_o,	// shared by all queues
	output logic que_full_o
);
	import msi_pkg::*;

	logic core_hit;
	logic accept;
	logic [NUM_PRI:1] wr_dec;	// decoded strobe before the register

	assign core_hit = (msg_core_i == coreno_i) || (msg_core_i == BCAST_CORE);
	assign accept = msg_valid_i && core_hit && (msg_pri_i != '0);	// pri 0 dropped

	// priority number to one-hot queue select
	always_comb begin
		wr_dec = '0;
		for (int p = 1; p <= NUM_PRI; p++)
			wr_dec[p] = accept && (msg_pri_i == PRI_W'(p));
	end

	// strobe lands in the queue one edge after the message was sampled
	always_ff @(posedge clk) begin
		if (rst)
			q_wr_o <= '0;
		else
			q_wr_o <= wr_dec;
	end

	always_ff @(posedge clk)
		q_din_o <= {msg_vec_i, msg_dat_i};	// message word

	// sticky overflow flag
	// a write that meets a full queue is lost, set wins over clear
	always_ff @(posedge clk) begin
		if (rst)
			que_full_o <= 1'b0;
		else if (|(q_wr_o & q_full_i))
			que_full_o <= 1'b1;
		else if (full_clr_i)
			que_full_o <= 1'b0;
	end

endmodule

/* msi_arbiter.sv */
/*
  interrupt arbiter of the msi controller
  picks the highest waiting priority above ipl, pops it, looks up the
  vector and holds irq with address, data and priority until the ack
  sequence is idle, lookup, present
*/
`timescale 1ns/10ps

module msi_arbiter (
	input  logic clk,
	input  logic rst,
	input  logic [msi_pkg::NUM_PRI:1] q_empty_i,
	input  logic [msi_pkg::NUM_PRI:1][msi_pkg::MSG_W-1:0] q_head_i,
	input  logic [msi_pkg::PRI_W-1:0] ipl_i,	// core's current level
	input  logic irq_ack_i,
	input  logic vt_mask_i,
	input  logic [msi_pkg::ADR_W-1:0] vt_adr_i,
	input  logic [msi_pkg::DAT_W-1:0] vt_dat_i,
	output logic [msi_pkg::NUM_PRI:1] q_rd_o,	// pop strobes
	output logic [msi_pkg::VEC_W-1:0] vt_ridx_o,
	output logic irq_o,
	output logic [msi_pkg::ADR_W-1:0] ivect_o,	// isr address
	output logic [msi_pkg::DAT_W-1:0] idat_o,
	output logic [msi_pkg::PRI_W-1:0] ipri_o
);
	import msi_pkg::*;

	logic lkup_q;	// lookup state, table entry arrives
	logic pres_q;	// present state, irq held
	logic idle;
	logic found;
	logic [PRI_W-1:0] sel_pri;	// highest non-empty queue
	logic take;
	logic [MSG_W-1:0] head;
	logic [VEC_W-1:0] vec_q;
	logic [DAT_W-1:0] dat_q;	// message data of the popped word

	// ==========================================================
	// priority encoder
	// ==========================================================
	always_comb begin
		found = 1'b0;
		sel_pri = '0;
		for (int p = 1; p <= NUM_PRI; p++) begin
			if (!q_empty_i[p]) begin
				found = 1'b1;
				sel_pri = PRI_W'(p);	// later wins, so highest
			end
		end
	end

	assign idle = !lkup_q && !pres_q;
	assign take = idle && found && (sel_pri > ipl_i);	// lower ones wait
	assign head = q_head_i[sel_pri];

	always_comb begin
		q_rd_o = '0;
		if (take)
			q_rd_o[sel_pri] = 1'b1;
	end

	// table read is registered, entry shows up in lookup
	assign vt_ridx_o = idle ? head[MSG_W-1:DAT_W] : vec_q;

	// ==========================================================
	// sequence
	// ==========================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			lkup_q <= 1'b0;
			pres_q <= 1'b0;
		end
		else begin
			lkup_q <= take;	// lookup lasts one cycle
			if (lkup_q && !vt_mask_i)
				pres_q <= 1'b1;	// masked entry goes back to idle
			else if (irq_ack_i)
				pres_q <= 1'b0;
		end
	end

	assign irq_o = pres_q;

	// latched on pop and on lookup, stable for the whole present state
	always_ff @(posedge clk) begin
		if (take) begin
			vec_q <= head[MSG_W-1:DAT_W];
			dat_q <= head[DAT_W-1:0];
			ipri_o <= sel_pri;
		end
		if (lkup_q) begin
			ivect_o <= vt_adr_i;
			idat_o <= dat_q;	// message data goes out as it came in
		end
	end

endmodule

/* msi_vector_table.sv */
/*
  vector table of the msi controller
  one entry per vector holds an isr address, a data word and a mask
  written one half at a time and read through a registered port
*/
`timescale 1ns/10ps

module msi_vector_table (
	input  logic clk,
	input  logic we_i,
	input  logic [msi_pkg::VEC_W-1:0] widx_i,
	input  logic whalf_i,	// 0 = address half, 1 = control half
	input  msi_pkg::vt_wword_u wword_i,
	input  logic [msi_pkg::VEC_W-1:0] ridx_i,
	output logic mask_o,
	output logic [msi_pkg::ADR_W-1:0] adr_o,
	output logic [msi_pkg::DAT_W-1:0] dat_o
);
	import msi_pkg::*;

	logic [ADR_W-1:0] adr_mem [NUM_VEC];	// isr addresses
	logic [DAT_W-1:0] dat_mem [NUM_VEC];	// isr data words
	logic mask_mem [NUM_VEC];
	logic wr_adr;
	logic wr_ctl;

	// ==========================================================
	// write port
	// ==========================================================
	assign wr_adr = we_i && !whalf_i;
	assign wr_ctl = we_i && whalf_i;

	always_ff @(posedge clk) begin
		if (wr_adr)
			adr_mem[widx_i] <= wword_i.adr_view;	// whole word is the address
	end

	// control half updates data and mask together
	always_ff @(posedge clk) begin
		if (wr_ctl) begin
			dat_mem[widx_i] <= wword_i.ctl_view.dat;
			mask_mem[widx_i] <= wword_i.ctl_view.mask;
		end
	end

	// ==========================================================
	// read port
	// ==========================================================
	// one cycle from index to entry, same as a block ram
	always_ff @(posedge clk) begin
		adr_o <= adr_mem[ridx_i];
		dat_o <= dat_mem[ridx_i];
		mask_o <= mask_mem[ridx_i];
	end

endmodule

/* msi_controller.sv */
/*
  msi interrupt controller for one cpu core
  intake, fifteen priority queues, arbiter and vector table
  irq_o is held with ivect_o, idat_o and ipri_o until irq_ack_i
*/
`timescale 1ns/10ps

module msi_controller (
	input  logic clk,
	input  logic rst,
	input  logic msg_valid_i,
	input  logic [msi_pkg::CORE_W-1:0] msg_core_i,
	input  logic [msi_pkg::PRI_W-1:0] msg_pri_i,
	input  logic [msi_pkg::VEC_W-1:0] msg_vec_i,
	input  logic [msi_pkg::DAT_W-1:0] msg_dat_i,
	input  logic [msi_pkg::CORE_W-1:0] coreno_i,
	input  logic [msi_pkg::PRI_W-1:0] ipl_i,
	input  logic vt_we_i,
	input  logic [msi_pkg::VEC_W-1:0] vt_idx_i,
	input  logic vt_half_i,
	input  msi_pkg::vt_wword_u vt_wdat_i,
	input  logic full_clr_i,
	input  logic irq_ack_i,
	output logic irq_o,
	output logic [msi_pkg::ADR_W-1:0] ivect_o,
	output logic [msi_pkg::DAT_W-1:0] idat_o,
	output logic [msi_pkg::PRI_W-1:0] ipri_o,
	output logic que_full_o
);
	import msi_pkg::*;

	logic [NUM_PRI:1] q_wr;
	logic [MSG_W-1:0] q_din;
	logic [NUM_PRI:1] q_full;
	logic [NUM_PRI:1] q_empty;
	logic [NUM_PRI:1][MSG_W-1:0] q_head;
	logic [NUM_PRI:1] q_rd;
	logic [VEC_W-1:0] vt_ridx;
	logic vt_mask;
	logic [ADR_W-1:0] vt_adr;
	logic [DAT_W-1:0] vt_dat;

	msi_intake intake_inst (
		.clk(clk), .rst(rst),
		.msg_valid_i(msg_valid_i), .msg_core_i(msg_core_i), .msg_pri_i(msg_pri_i),
		.msg_vec_i(msg_vec_i), .msg_dat_i(msg_dat_i), .coreno_i(coreno_i),
		.q_full_i(q_full), .full_clr_i(full_clr_i),
		.q_wr_o(q_wr), .q_din_o(q_din), .que_full_o(que_full_o)
	);

	// ==========================================================
	// one queue per priority, index = priority
	// ==========================================================
	for (genvar g = 1; g <= NUM_PRI; g++) begin : g_que
		msi_queue que_inst (
			.clk(clk), .rst(rst),
			.wr_i(q_wr[g]), .din_i(q_din), .rd_i(q_rd[g]),
			.empty_o(q_empty[g]), .full_o(q_full[g]), .dout_o(q_head[g])
		);
	end

	msi_arbiter arbiter_inst (
		.clk(clk), .rst(rst),
		.q_empty_i(q_empty), .q_head_i(q_head), .ipl_i(ipl_i), .irq_ack_i(irq_ack_i),
		.vt_mask_i(vt_mask), .vt_adr_i(vt_adr), .vt_dat_i(vt_dat),
		.q_rd_o(q_rd), .vt_ridx_o(vt_ridx),
		.irq_o(irq_o), .ivect_o(ivect_o), .idat_o(idat_o), .ipri_o(ipri_o)
	);

	msi_vector_table vtbl_inst (
		.clk(clk),
		.we_i(vt_we_i), .widx_i(vt_idx_i), .whalf_i(vt_half_i), .wword_i(vt_wdat_i),
		.ridx_i(vt_ridx),
		.mask_o(vt_mask), .adr_o(vt_adr), .dat_o(vt_dat)
	);

endmodule

/* msi_controller_props.sv */
/*
  concurrent checks on the interrupt outputs of the msi controller
  bound into the controller at the bottom of this file
*/
`timescale 1ns/10ps

module msi_controller_props (
	input logic clk,
	input logic rst,
	input logic irq_i,
	input logic [msi_pkg::ADR_W-1:0] ivect_i,
	input logic [msi_pkg::DAT_W-1:0] idat_i,
	input logic [msi_pkg::PRI_W-1:0] ipri_i,
	input logic [msi_pkg::PRI_W-1:0] ipl_i
);
	// irq cleared by the reset cycle
	a_rst_low: assert property (@(posedge clk) rst |=> !irq_i)
		else $error("irq_o high while in reset");

	// payload held for the whole interrupt
	a_hold: assert property (@(posedge clk) disable iff (rst)
		irq_i && $past(irq_i) |-> $stable(ivect_i) && $stable(idat_i) && $stable(ipri_i))
		else $error("irq payload changed while irq_o was high");

	a_above_ipl: assert property (@(posedge clk) disable iff (rst) $rose(irq_i) |-> ipri_i > ipl_i)
		else $error("irq_o rose with ipri_o not above ipl_i");

endmodule

bind msi_controller msi_controller_props props_inst (
	.clk(clk), .rst(rst), .irq_i(irq_o), .ivect_i(ivect_o),
	.idat_i(idat_o), .ipri_i(ipri_o), .ipl_i(ipl_i)
);

/* msi_controller_tb.sv */
/*
  testbench of the msi interrupt controller
  drives messages and table writes on the falling clock edge, keeps a
  model of the queues and the vector table, and checks every interrupt
*/
`timescale 1ns/10ps

module msi_controller_tb;
	import msi_pkg::*;

	localparam int TEST_CYC = 400;	// cycle budget of one test
	localparam logic [CORE_W-1:0] ME = 6'd12;	// core number of the dut
	localparam logic [CORE_W-1:0] OTHER = 6'd5;

	logic clk, rst, msg_valid_i, vt_we_i, vt_half_i, full_clr_i, irq_ack_i, irq_o, que_full_o;
	logic [CORE_W-1:0] msg_core_i, coreno_i;
	logic [PRI_W-1:0] msg_pri_i, ipl_i, ipri_o;
	logic [VEC_W-1:0] msg_vec_i, vt_idx_i;
	logic [DAT_W-1:0] msg_dat_i, idat_o;
	logic [ADR_W-1:0] ivect_o;
	vt_wword_u vt_wdat_i;

	// ==========================================================
	// reference model state
	// ==========================================================
	logic [MSG_W-1:0] mq [1:NUM_PRI][QDEPTH];	// model queues, index 0 is the head
	int mq_cnt [1:NUM_PRI];
	logic [ADR_W-1:0] m_adr [NUM_VEC];
	logic [DAT_W-1:0] m_dat [NUM_VEC];
	logic m_mask [NUM_VEC];
	logic m_full;	// expected sticky flag
	integer seed;
	int cycles, test_start, test_no, err_cnt, err_base, chk_cnt, fail_tests, irq_cnt, irq_base;
	logic busy, hold_ack;	// compare process is handling an irq / ack held back

	msi_controller msi_controller_inst (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns period
	end

	// per test cycle limit
	initial begin
		while (cycles - test_start < TEST_CYC) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: test %0d did not finish within %0d cycles", test_no, TEST_CYC);
		$display("CHECKS FAILED");
		$finish;
	end

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// expected next interrupt
	// highest waiting priority above ipl in fifo order, masked entries dropped at lookup
	function automatic logic ref_next(output logic [PRI_W-1:0] pri, output logic [ADR_W-1:0] adr,
		output logic [DAT_W-1:0] dat);
		int sel;
		logic found;
		logic [MSG_W-1:0] w;
		logic [VEC_W-1:0] v;
		found = 1'b0;
		pri = '0;
		adr = '0;
		dat = '0;
		for (int k = 0; k < NUM_PRI * QDEPTH; k++) begin
			sel = 0;
			for (int p = 1; p <= NUM_PRI; p++)
				if (mq_cnt[p] != 0 && PRI_W'(p) > ipl_i)
					sel = p;
			if (sel != 0 && !found) begin
				w = mq[sel][0];
				for (int i = 0; i < QDEPTH - 1; i++)
					mq[sel][i] = mq[sel][i + 1];	// pop the head
				mq_cnt[sel]--;
				v = w[MSG_W-1:DAT_W];
				if (!m_mask[v]) begin
					found = 1'b1;
					pri = PRI_W'(sel);
					adr = m_adr[v];
					dat = w[DAT_W-1:0];	// message data
				end
			end
		end
		return found;
	endfunction

	// ==========================================================
	// compare process, one pass per presented interrupt
	// ==========================================================
	initial begin : compare_proc
		logic [PRI_W-1:0] e_pri;
		logic [ADR_W-1:0] e_adr;
		logic [DAT_W-1:0] e_dat;
		irq_ack_i = 1'b0;
		busy = 1'b0;
		forever begin
			@(negedge clk);
			if (irq_o === 1'b1) begin
				busy = 1'b1;
				irq_cnt++;
				if (ref_next(e_pri, e_adr, e_dat)) begin
					check_val("ipri_o", 64'(e_pri), 64'(ipri_o));
					check_val("ivect_o", 64'(e_adr), 64'(ivect_o));
					check_val("idat_o", 64'(e_dat), 64'(idat_o));
				end
				else begin
					err_cnt++;
					$display("unexpected interrupt at %0t: no message is waiting above ipl", $time);
				end
				while (hold_ack)
					@(negedge clk);
				irq_ack_i = 1'b1;
				@(negedge clk);
				irq_ack_i = 1'b0;
				check_val("irq_o", 64'(1'b0), 64'(irq_o));	// low the cycle after the ack
				busy = 1'b0;
			end
		end
	end

	task automatic write_entry(input logic [VEC_W-1:0] idx, input logic mask);
		m_adr[idx] = {8'($random(seed)), 32'($random(seed))};
		m_dat[idx] = $random(seed);
		m_mask[idx] = mask;
		vt_we_i = 1'b1;
		vt_idx_i = idx;
		vt_half_i = 1'b0;	// address half first
		vt_wdat_i = m_adr[idx];
		@(negedge clk);
		vt_half_i = 1'b1;
		vt_wdat_i = '0;
		vt_wdat_i.ctl_view.dat = m_dat[idx];
		vt_wdat_i.ctl_view.mask = mask;
		@(negedge clk);
		vt_we_i = 1'b0;
	endtask

	task automatic send_msg(input logic [CORE_W-1:0] core, input logic [PRI_W-1:0] pri,
		input logic [VEC_W-1:0] vec);
		msg_valid_i = 1'b1;
		{msg_core_i, msg_pri_i, msg_vec_i} = {core, pri, vec};
		msg_dat_i = $random(seed);
		if ((core == coreno_i || core == BCAST_CORE) && pri != '0) begin
			if (mq_cnt[pri] < QDEPTH) begin
				mq[pri][mq_cnt[pri]] = {vec, msg_dat_i};
				mq_cnt[pri]++;
			end
			else
				m_full = 1'b1;	// dropped, flag goes sticky
		end
		@(negedge clk);
		msg_valid_i = 1'b0;
	endtask

	// counters are sampled at the rising edge, where they are stable
	task automatic wait_irqs(input int target);
		@(posedge clk);
		while (irq_cnt < target || (busy && !hold_ack))
			@(posedge clk);
		@(negedge clk);
	endtask

	task automatic start_test(input int n);
		test_no = n;
		test_start = cycles;
		err_base = err_cnt;
		irq_base = irq_cnt;
	endtask

	task automatic end_test(input string name);
		repeat (20) @(negedge clk);	// any late irq shows up as unexpected
		if (err_cnt != err_base)
			fail_tests++;
		$display("test %0d %s: %s", test_no, name, (err_cnt == err_base) ? "ok" : "failed");
	endtask

	// ==========================================================
	// stimulus
	// ==========================================================
	initial begin
		seed = 32'hddb6_bd49;
		rst = 1'b1;
		{msg_valid_i, vt_we_i, vt_half_i, full_clr_i, hold_ack, m_full} = '0;
		{msg_core_i, msg_pri_i, msg_vec_i, msg_dat_i, vt_idx_i, ipl_i} = '0;
		vt_wdat_i = '0;
		coreno_i = ME;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		for (int v = 10; v < 16; v++)
			write_entry(VEC_W'(v), v == 13);	// vector 13 masked

		start_test(1);
		check_val("que_full_o", 64'(1'b0), 64'(que_full_o));
		send_msg(ME, 4'd7, 6'd10);
		wait_irqs(irq_base + 1);
		end_test("single message");

		start_test(2);
		hold_ack = 1'b1;	// keep the first irq up while more arrive
		send_msg(ME, 4'd3, 6'd11);
		wait_irqs(irq_base + 1);
		send_msg(ME, 4'd7, 6'd12);
		send_msg(ME, 4'd2, 6'd14);
		send_msg(ME, 4'd7, 6'd15);
		send_msg(ME, 4'd12, 6'd10);
		send_msg(ME, 4'd2, 6'd11);
		hold_ack = 1'b0;
		wait_irqs(irq_base + 6);
		end_test("held interrupt and queue order");

		start_test(3);
		ipl_i = 4'd15;	// nothing taken while loading
		send_msg(OTHER, 4'd9, 6'd10);
		send_msg(ME, 4'd0, 6'd11);
		send_msg(BCAST_CORE, 4'd4, 6'd12);
		send_msg(ME, 4'd6, 6'd14);
		send_msg(ME, 4'd2, 6'd15);
		ipl_i = 4'd5;
		wait_irqs(irq_base + 1);
		repeat (30) @(negedge clk);	// 4 and 2 stay queued
		ipl_i = 4'd0;
		wait_irqs(irq_base + 3);
		end_test("core filter, broadcast and ipl");

		start_test(4);
		ipl_i = 4'd15;
		send_msg(ME, 4'd9, 6'd13);
		send_msg(ME, 4'd9, 6'd12);
		send_msg(ME, 4'd7, 6'd13);
		send_msg(ME, 4'd6, 6'd11);
		ipl_i = 4'd0;
		wait_irqs(irq_base + 2);
		end_test("masked entries");

		start_test(5);
		ipl_i = 4'd15;
		repeat (QDEPTH + 2)
			send_msg(ME, 4'd5, 6'd14);
		repeat (2) @(negedge clk);
		check_val("que_full_o", 64'(m_full), 64'(que_full_o));
		ipl_i = 4'd0;
		wait_irqs(irq_base + QDEPTH);
		check_val("que_full_o", 64'(m_full), 64'(que_full_o));	// still sticky
		full_clr_i = 1'b1;
		m_full = 1'b0;
		@(negedge clk);
		full_clr_i = 1'b0;
		check_val("que_full_o", 64'(m_full), 64'(que_full_o));
		end_test("queue overflow");

		$display("5 tests, %0d failed, %0d checks, %0d errors", fail_tests, chk_cnt, err_cnt);
		if (err_cnt == 0 && fail_tests == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* sources.f */
msi_pkg.sv
msi_queue.sv
msi_intake.sv
msi_arbiter.sv
msi_vector_table.sv
msi_controller.sv
msi_controller_props.sv
msi_controller_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module msi_controller_tb -o msi_sim
out=$(./obj_dir/msi_sim)
echo "$out"
if echo "$out" | grep -q "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1
